//--- rtl/spu_pkg.sv
package spu_pkg;

	localparam int data_w     = 128;	// Register width
	localparam int reg_addr_w = 7;		// 128 registers
	localparam int op_w       = 11;
	localparam int wb_adr_w   = 10;		// Word address
	localparam int wb_dat_w   = 32;
	localparam int pipe_depth = 4;		// Result stages in the byte unit

	// Wishbone word address map
	localparam int adr_region_bit = 9;		// Selects instruction port or register window
	localparam int adr_reg_msb    = 8;		// Register number in bits 8 to 2
	localparam int adr_reg_lsb    = 2;
	localparam int adr_word_msb   = 1;		// Word in register, word 0 most significant
	localparam logic adr_region_reg = 1'b1;

	// Instruction word fields, opcode on top, then rb, ra, rt
	localparam int ins_op_lsb = 21;
	localparam int ins_rb_lsb = 14;
	localparam int ins_ra_lsb = 7;
	localparam int ins_rt_lsb = 0;

	typedef enum logic [op_w-1:0] {
		op_nop   = 11'b00000000000,
		op_cntb  = 11'b01010110100,	// Count ones in bytes
		op_avgb  = 11'b00011010011,	// Average bytes
		op_absdb = 11'b00001010011,	// Absolute difference of bytes
		op_sumb  = 11'b01001010011		// Sum bytes into halfwords
	} byte_op_t;

	typedef enum logic {
		st_idle,
		st_ack		// Acknowledge cycle
	} issue_state_t;

endpackage

//--- rtl/spu_reg_file.sv
`timescale 1ns/1ps

module spu_reg_file (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [0:spu_pkg::reg_addr_w-1] ra_addr,
	input  logic [0:spu_pkg::reg_addr_w-1] rb_addr,
	output logic [0:spu_pkg::data_w-1]     ra_data,
	output logic [0:spu_pkg::data_w-1]     rb_data,
	input  logic                           wb_en,		// Writeback from the byte unit
	input  logic [0:spu_pkg::reg_addr_w-1] wb_addr,
	input  logic [0:spu_pkg::data_w-1]     wb_data,
	input  logic                           host_we,		// Host word write
	input  logic [0:spu_pkg::reg_addr_w-1] host_addr,
	input  logic [1:0]                     host_word,
	input  logic [spu_pkg::wb_dat_w-1:0]   host_data,
	output logic                           host_busy
);

	logic [0:spu_pkg::data_w-1] regs [0:(1 << spu_pkg::reg_addr_w)-1];

	assign ra_data   = regs[ra_addr];	// Asynchronous reads
	assign rb_data   = regs[rb_addr];
	assign host_busy = host_we && wb_en;	// Writeback owns the port this cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << spu_pkg::reg_addr_w); i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end else if (host_we) begin
			regs[host_addr][host_word * spu_pkg::wb_dat_w +: spu_pkg::wb_dat_w] <= host_data;
		end
	end

	// The hazard check keeps the host off a register whose writeback is in flight
	no_same_reg_collision: assert property (@(posedge clk) disable iff (reset)
		!(wb_en && host_we && host_addr == wb_addr));

endmodule

//--- rtl/spu_byte_unit.sv
`timescale 1ns/1ps

module spu_byte_unit (
	input  logic                           clk,
	input  logic                           reset,
	input  spu_pkg::byte_op_t              op,
	input  logic [0:spu_pkg::reg_addr_w-1] rt_addr,		// Destination register
	input  logic                           reg_write,
	input  logic [0:spu_pkg::data_w-1]     ra,
	input  logic [0:spu_pkg::data_w-1]     rb,
	input  logic [0:spu_pkg::reg_addr_w-1] src_a_addr,
	input  logic [0:spu_pkg::reg_addr_w-1] src_b_addr,
	output logic [0:spu_pkg::data_w-1]     rt_wb,
	output logic [0:spu_pkg::reg_addr_w-1] rt_addr_wb,
	output logic                           reg_write_wb,
	output logic                           stall_raw
);

	logic [0:spu_pkg::data_w-1]     result;		// Value entering stage 0
	logic                           known;		// Opcode produces a result
	logic [0:spu_pkg::data_w-1]     rt_delay [spu_pkg::pipe_depth];
	logic [0:spu_pkg::reg_addr_w-1] rt_addr_delay [spu_pkg::pipe_depth];
	logic [spu_pkg::pipe_depth-1:0] valid_delay;	// Bit 0 is the first stage

	always_comb begin
		result = '0;
		known  = 1'b1;
		case (op)
			spu_pkg::op_cntb: begin
				for (int i = 0; i < spu_pkg::data_w / 8; i++) begin
					result[i*8 +: 8] = 8'($countones(ra[i*8 +: 8]));
				end
			end
			spu_pkg::op_avgb: begin
				for (int i = 0; i < spu_pkg::data_w / 8; i++) begin
					result[i*8 +: 8] = 8'((9'(ra[i*8 +: 8]) + 9'(rb[i*8 +: 8]) + 9'd1) >> 1);
				end
			end
			spu_pkg::op_absdb: begin
				for (int i = 0; i < spu_pkg::data_w / 8; i++) begin
					if ($signed(ra[i*8 +: 8]) > $signed(rb[i*8 +: 8])) begin
						result[i*8 +: 8] = ra[i*8 +: 8] - rb[i*8 +: 8];
					end else begin
						result[i*8 +: 8] = rb[i*8 +: 8] - ra[i*8 +: 8];
					end
				end
			end
			spu_pkg::op_sumb: begin
				// rb sum to the upper halfword of each word, ra sum to the lower
				for (int i = 0; i < spu_pkg::data_w / 32; i++) begin
					result[i*32 +: 16] = 16'($signed(rb[i*32 +: 8]))
						+ 16'($signed(rb[i*32+8 +: 8]))
						+ 16'($signed(rb[i*32+16 +: 8]))
						+ 16'($signed(rb[i*32+24 +: 8]));
					result[i*32+16 +: 16] = 16'($signed(ra[i*32 +: 8]))
						+ 16'($signed(ra[i*32+8 +: 8]))
						+ 16'($signed(ra[i*32+16 +: 8]))
						+ 16'($signed(ra[i*32+24 +: 8]));
				end
			end
			default: begin
				known = 1'b0;	// nop and undefined opcodes
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_delay <= '0;
		end else begin
			valid_delay <= {valid_delay[spu_pkg::pipe_depth-2:0], reg_write && known};
		end
	end

	always_ff @(posedge clk) begin
		rt_delay[0]      <= result;
		rt_addr_delay[0] <= rt_addr;
		for (int i = 1; i < spu_pkg::pipe_depth; i++) begin
			rt_delay[i]      <= rt_delay[i-1];
			rt_addr_delay[i] <= rt_addr_delay[i-1];
		end
	end

	assign rt_wb        = rt_delay[spu_pkg::pipe_depth-1];
	assign rt_addr_wb   = rt_addr_delay[spu_pkg::pipe_depth-1];
	assign reg_write_wb = valid_delay[spu_pkg::pipe_depth-1];

	// No forwarding, so the last stage counts until the register file holds it
	always_comb begin
		stall_raw = 1'b0;
		for (int i = 0; i < spu_pkg::pipe_depth; i++) begin
			if (valid_delay[i] &&
				(rt_addr_delay[i] == src_a_addr || rt_addr_delay[i] == src_b_addr)) begin
				stall_raw = 1'b1;
			end
		end
	end

	// Issue never sends an instruction whose sources are still in flight
	no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
		reg_write |-> !stall_raw);

endmodule

//--- rtl/spu_issue.sv
`timescale 1ns/1ps

module spu_issue (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [spu_pkg::wb_adr_w-1:0]   wb_adr,
	input  logic [spu_pkg::wb_dat_w-1:0]   wb_dat_w,
	output logic [spu_pkg::wb_dat_w-1:0]   wb_dat_r,
	output logic                           wb_ack,
	output logic [0:spu_pkg::reg_addr_w-1] ra_addr,
	output logic [0:spu_pkg::reg_addr_w-1] rb_addr,
	input  logic [0:spu_pkg::data_w-1]     ra_data,
	input  logic [0:spu_pkg::data_w-1]     rb_data,
	output spu_pkg::byte_op_t              op,
	output logic [0:spu_pkg::reg_addr_w-1] rt_addr,
	output logic                           reg_write,
	output logic [0:spu_pkg::data_w-1]     ra,
	output logic [0:spu_pkg::data_w-1]     rb,
	output logic [0:spu_pkg::reg_addr_w-1] src_a_addr,
	output logic [0:spu_pkg::reg_addr_w-1] src_b_addr,
	input  logic                           stall_raw,
	output logic                           host_we,
	output logic [0:spu_pkg::reg_addr_w-1] host_addr,
	output logic [1:0]                     host_word,
	output logic [spu_pkg::wb_dat_w-1:0]   host_data,
	input  logic                           host_busy
);

	spu_pkg::issue_state_t state;

	logic                           pending;	// Transfer requested by the master
	logic                           is_reg;		// Register window access
	logic [0:spu_pkg::reg_addr_w-1] win_addr;
	logic [1:0]                     win_word;
	logic                           accept;		// Transfer taken on this edge

	assign pending  = wb_cyc && wb_stb;
	assign is_reg   = wb_adr[spu_pkg::adr_region_bit] == spu_pkg::adr_region_reg;
	assign win_addr = wb_adr[spu_pkg::adr_reg_msb:spu_pkg::adr_reg_lsb];
	assign win_word = wb_adr[spu_pkg::adr_word_msb:0];

	// A window access checks hazards against the addressed register itself
	assign src_a_addr = is_reg ? win_addr
		: wb_dat_w[spu_pkg::ins_ra_lsb +: spu_pkg::reg_addr_w];
	assign src_b_addr = is_reg ? win_addr
		: wb_dat_w[spu_pkg::ins_rb_lsb +: spu_pkg::reg_addr_w];
	assign ra_addr = src_a_addr;
	assign rb_addr = src_b_addr;
	assign ra      = ra_data;
	assign rb      = rb_data;

	assign op      = spu_pkg::byte_op_t'(wb_dat_w[spu_pkg::ins_op_lsb +: spu_pkg::op_w]);
	assign rt_addr = wb_dat_w[spu_pkg::ins_rt_lsb +: spu_pkg::reg_addr_w];

	assign host_we   = pending && state == spu_pkg::st_idle && !stall_raw && is_reg && wb_we;
	assign host_addr = win_addr;
	assign host_word = win_word;
	assign host_data = wb_dat_w;

	assign accept    = pending && state == spu_pkg::st_idle && !stall_raw
		&& !(host_we && host_busy);	// Host write retries after a writeback
	assign reg_write = accept && !is_reg && wb_we && op != spu_pkg::op_nop;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= spu_pkg::st_idle;
		end else begin
			case (state)
				spu_pkg::st_idle: if (accept) state <= spu_pkg::st_ack;
				default:          state <= spu_pkg::st_idle;
			endcase
		end
	end

	assign wb_ack = state == spu_pkg::st_ack;

	always_ff @(posedge clk) begin
		if (accept && is_reg && !wb_we) begin
			wb_dat_r <= ra_data[win_word * spu_pkg::wb_dat_w +: spu_pkg::wb_dat_w];
		end
	end

	// The master keeps the strobe up until it has seen the acknowledge
	ack_with_request: assert property (@(posedge clk) disable iff (reset)
		$rose(wb_ack) |-> wb_cyc && wb_stb);

endmodule

//--- rtl/spu_byte_top.sv
`timescale 1ns/1ps

module spu_byte_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [spu_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [spu_pkg::wb_dat_w-1:0] wb_dat_w,
	output logic [spu_pkg::wb_dat_w-1:0] wb_dat_r,
	output logic                         wb_ack
);

	logic [0:spu_pkg::reg_addr_w-1] ra_addr, rb_addr;
	logic [0:spu_pkg::data_w-1]     ra_data, rb_data;
	spu_pkg::byte_op_t              op;
	logic [0:spu_pkg::reg_addr_w-1] rt_addr;
	logic                           reg_write;
	logic [0:spu_pkg::data_w-1]     ra, rb;
	logic [0:spu_pkg::reg_addr_w-1] src_a_addr, src_b_addr;
	logic                           stall_raw;
	logic                           host_we;
	logic [0:spu_pkg::reg_addr_w-1] host_addr;
	logic [1:0]                     host_word;
	logic [spu_pkg::wb_dat_w-1:0]   host_data;
	logic                           host_busy;
	logic [0:spu_pkg::data_w-1]     rt_wb;		// Writeback path
	logic [0:spu_pkg::reg_addr_w-1] rt_addr_wb;
	logic                           reg_write_wb;

	spu_issue u_spu_issue (
		.clk, .reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.ra_addr, .rb_addr, .ra_data, .rb_data,
		.op, .rt_addr, .reg_write, .ra, .rb,
		.src_a_addr, .src_b_addr, .stall_raw,
		.host_we, .host_addr, .host_word, .host_data, .host_busy
	);

	spu_reg_file u_spu_reg_file (
		.clk, .reset,
		.ra_addr, .rb_addr, .ra_data, .rb_data,
		.wb_en(reg_write_wb), .wb_addr(rt_addr_wb), .wb_data(rt_wb),
		.host_we, .host_addr, .host_word, .host_data, .host_busy
	);

	spu_byte_unit u_spu_byte_unit (
		.clk, .reset,
		.op, .rt_addr, .reg_write, .ra, .rb,
		.src_a_addr, .src_b_addr,
		.rt_wb, .rt_addr_wb, .reg_write_wb, .stall_raw
	);

endmodule

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit xorshift step, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic logic [127:0] popcount_bytes(input logic [127:0] a);
	logic [127:0] r;
	int           n;
	r = '0;
	for (int i = 0; i < 16; i++) begin
		n = 0;
		for (int j = 0; j < 8; j++) begin
			if (a[i*8+j]) n++;
		end
		r[i*8 +: 8] = 8'(n);
	end
	return r;
endfunction

function automatic logic [127:0] avg_bytes(input logic [127:0] a, input logic [127:0] b);
	logic [127:0] r;
	int           s;
	r = '0;
	for (int i = 0; i < 16; i++) begin
		s = int'(a[i*8 +: 8]) + int'(b[i*8 +: 8]) + 1;	// Unsigned, rounds up
		r[i*8 +: 8] = 8'(s >> 1);
	end
	return r;
endfunction

function automatic logic [127:0] absdiff_bytes(input logic [127:0] a, input logic [127:0] b);
	logic [127:0] r;
	int           d;
	r = '0;
	for (int i = 0; i < 16; i++) begin
		d = int'($signed(a[i*8 +: 8])) - int'($signed(b[i*8 +: 8]));
		if (d < 0) d = -d;
		r[i*8 +: 8] = 8'(d);
	end
	return r;
endfunction

// Each word gets the byte sum of b on top and of a below
function automatic logic [127:0] sum_bytes_to_halves(input logic [127:0] a, input logic [127:0] b);
	logic [127:0] r;
	int           sa;
	int           sb;
	r = '0;
	for (int w = 0; w < 4; w++) begin
		sa = 0;
		sb = 0;
		for (int k = 0; k < 4; k++) begin
			sa += int'($signed(a[w*32+k*8 +: 8]));
			sb += int'($signed(b[w*32+k*8 +: 8]));
		end
		r[w*32+16 +: 16] = 16'(sb);
		r[w*32 +: 16]    = 16'(sa);
	end
	return r;
endfunction

`endif

//--- tests/tb_spu_byte.sv
`timescale 1ns/1ps

module tb_spu_byte;

	localparam logic [spu_pkg::wb_adr_w-1:0] ins_adr = '0;	// Instruction port, region bit clear
	localparam int word_cycles = 4;		// Upper bound for one bus word

	logic                         clk;
	logic                         reset;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [spu_pkg::wb_adr_w-1:0] wb_adr;
	logic [spu_pkg::wb_dat_w-1:0] wb_dat_w;
	logic [spu_pkg::wb_dat_w-1:0] wb_dat_r;
	logic                         wb_ack;

	logic [127:0] model_regs [128];	// Word 0 in bits 127:96
	string        name_q [$];
	logic [10:0]  op_q [$];
	int           ra_q [$];
	int           rb_q [$];
	int           rt_q [$];
	bit           check_q [$];		// Read rt back right after issue
	int           errors = 0;
	int           checks = 0;
	int           ack_count = 0;
	bit           table_ready = 0;
	int           watchdog_cycles;

	`include "tb_model.svh"

	spu_byte_top u_spu_byte_top (
		.clk, .reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
	);

	always #50 clk = ~clk;

	always @(negedge clk) begin
		if (wb_ack) ack_count++;
	end

	// Holds the request until an acknowledge is seen, drops it after that edge
	task automatic finish_transfer(output logic [31:0] data);
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		data = wb_dat_r;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [9:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		finish_transfer(ignored);
	endtask

	task automatic wb_read(input logic [9:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		finish_transfer(data);
	endtask

	function automatic logic [9:0] reg_word_adr(input int r, input int w);
		return {spu_pkg::adr_region_reg, 7'(r), 2'(w)};
	endfunction

	task automatic write_reg(input int r, input logic [127:0] value);
		for (int w = 0; w < 4; w++) begin
			wb_write(reg_word_adr(r, w), value[127-32*w -: 32]);
		end
		model_regs[r] = value;
	endtask

	task automatic check_reg(input string name, input int r);
		logic [31:0] actual;
		logic [31:0] expected;
		for (int w = 0; w < 4; w++) begin
			wb_read(reg_word_adr(r, w), actual);
			expected = model_regs[r][127-32*w -: 32];
			checks++;
			assert (actual === expected) else begin
				errors++;
				$display("FAILED %s r%0d word %0d: expected %h, actual %h",
					name, r, w, expected, actual);
			end
		end
	endtask

	function automatic logic [127:0] expected_result(input logic [10:0] op,
		input logic [127:0] a, input logic [127:0] b, input logic [127:0] old);
		case (op)
			spu_pkg::op_cntb:  return popcount_bytes(a);
			spu_pkg::op_avgb:  return avg_bytes(a, b);
			spu_pkg::op_absdb: return absdiff_bytes(a, b);
			spu_pkg::op_sumb:  return sum_bytes_to_halves(a, b);
			default:           return old;	// Nothing written
		endcase
	endfunction

	task automatic add_entry(input string name, input logic [10:0] op,
		input int ra, input int rb, input int rt, input bit check);
		name_q.push_back(name);
		op_q.push_back(op);
		ra_q.push_back(ra);
		rb_q.push_back(rb);
		rt_q.push_back(rt);
		check_q.push_back(check);
	endtask

	// r17 and r18 hold the 00, FF, 7F and 80 edge bytes
	task automatic build_table();
		add_entry("cntb_rand", spu_pkg::op_cntb, 1, 2, 20, 1);
		add_entry("cntb_edge", spu_pkg::op_cntb, 17, 18, 21, 1);
		add_entry("avgb_rand", spu_pkg::op_avgb, 3, 4, 22, 1);
		add_entry("avgb_edge", spu_pkg::op_avgb, 17, 18, 23, 1);
		add_entry("absdb_rand", spu_pkg::op_absdb, 5, 6, 24, 1);
		add_entry("absdb_edge", spu_pkg::op_absdb, 17, 18, 25, 1);
		add_entry("absdb_swap", spu_pkg::op_absdb, 18, 17, 26, 1);
		add_entry("sumb_rand", spu_pkg::op_sumb, 7, 8, 27, 1);
		add_entry("sumb_edge", spu_pkg::op_sumb, 17, 18, 28, 1);
		add_entry("nop_keep", spu_pkg::op_nop, 9, 10, 20, 1);
		add_entry("undef_keep", 11'h7FF, 11, 12, 21, 1);
		add_entry("chain_avgb", spu_pkg::op_avgb, 13, 14, 30, 0);	// Back-to-back chain
		add_entry("chain_absdb", spu_pkg::op_absdb, 30, 15, 31, 0);
		add_entry("chain_sumb", spu_pkg::op_sumb, 31, 30, 32, 0);
		add_entry("chain_cntb", spu_pkg::op_cntb, 32, 32, 33, 0);
		add_entry("chain_avgb2", spu_pkg::op_avgb, 33, 16, 34, 1);
		add_entry("self_dst", spu_pkg::op_avgb, 34, 1, 34, 1);
	endtask

	initial begin
		wait (table_ready);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0]  seed;
		logic [31:0]  first_word;
		logic [127:0] value;
		clk      = 1'b0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int i = 0; i < 128; i++) begin
			model_regs[i] = '0;
		end
		build_table();
		// Words outside the table: reset reads, preload, readback and sweep
		watchdog_cycles = name_q.size() * 40 + (13 + 18 * 4 + 8 + 48 * 4) * word_cycles + 20;
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		wb_read(reg_word_adr(0, 0), first_word);
		@(negedge clk);
		#1;
		checks++;
		assert (first_word === 32'h0) else begin
			errors++;
			$display("FAILED reset_first: expected %h, actual %h", 32'h0, first_word);
		end
		assert (ack_count == 1) else begin
			errors++;
			$display("First read after reset saw %0d acknowledges instead of one", ack_count);
		end
		@(posedge clk);
		#1;
		check_reg("reset_zero", 0);
		check_reg("reset_zero", 64);
		check_reg("reset_zero", 127);

		seed = 32'd88900;
		for (int r = 1; r <= 16; r++) begin
			for (int w = 0; w < 4; w++) begin
				seed = xorshift32(seed);
				value[127-32*w -: 32] = seed;
			end
			write_reg(r, value);
		end
		write_reg(17, 128'h00FF7F80_807F00FF_7F8000FF_FF807F00);
		write_reg(18, 128'h807FFF00_80807F7F_0000FFFF_01FE7F80);
		check_reg("readback", 17);
		check_reg("readback", 18);

		for (int i = 0; i < name_q.size(); i++) begin
			wb_write(ins_adr, {op_q[i], 7'(rb_q[i]), 7'(ra_q[i]), 7'(rt_q[i])});
			model_regs[rt_q[i]] = expected_result(op_q[i], model_regs[ra_q[i]],
				model_regs[rb_q[i]], model_regs[rt_q[i]]);
			if (check_q[i]) check_reg(name_q[i], rt_q[i]);
		end

		for (int r = 0; r < 48; r++) begin
			check_reg("sweep", r);	// Chain results and untouched registers
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+tests
rtl/spu_pkg.sv
rtl/spu_reg_file.sv
rtl/spu_byte_unit.sv
rtl/spu_issue.sv
rtl/spu_byte_top.sv
tests/tb_spu_byte.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spu_byte
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
